// ==== common/cpu_defs.svh ====
`ifndef CPU_DEFS_SVH
`define CPU_DEFS_SVH

// Datapath width
`define XLEN 32

// Architectural registers
`define REG_COUNT 32

// Data memory size in bytes
`define DMEM_BYTES 256

`endif

// ==== common/isaPkg.sv ====
`default_nettype none

package isaPkg;

    // Primary opcode field, instr[31:26]
    typedef enum logic [5:0] {
        opSpecial = 6'h00,
        opRegimm  = 6'h01,
        opJ       = 6'h02,
        opJal     = 6'h03,
        opBeq     = 6'h04,
        opBne     = 6'h05,
        opBlez    = 6'h06,
        opBgtz    = 6'h07,
        opAddi    = 6'h08,
        opSlti    = 6'h0A,
        opAndi    = 6'h0C,
        opOri     = 6'h0D,
        opXori    = 6'h0E,
        opMul     = 6'h1C,
        opLb      = 6'h20,
        opLh      = 6'h21,
        opLw      = 6'h23,
        opSb      = 6'h28,
        opSh      = 6'h29,
        opSw      = 6'h2B
    } opcodeE;

    // Function field under special, instr[5:0]
    // Mul takes the multiply slot so it cannot alias srl
    typedef enum logic [5:0] {
        fnSll = 6'h00, fnSrl = 6'h02, fnJr  = 6'h08, fnMul = 6'h18,
        fnAdd = 6'h20, fnSub = 6'h22, fnAnd = 6'h24, fnOr  = 6'h25,
        fnXor = 6'h26, fnNor = 6'h27, fnSlt = 6'h2A
    } functE;

    // Rt field under regimm
    typedef enum logic [4:0] {
        rmBltz = 5'h00,
        rmBgez = 5'h01
    } regimmE;

endpackage

`default_nettype wire

// ==== common/ctrlPkg.sv ====
`default_nettype none

package ctrlPkg;

    // ALU operation; aluUseFunct hands decode to the ALU
    typedef enum logic [3:0] {
        aluAdd, aluSub, aluAnd, aluOr, aluXor,
        aluNor, aluSlt, aluSll, aluSrl, aluMul,
        aluUseFunct = 4'hF
    } aluOpE;

    typedef enum logic [1:0] {dstRt, dstRd, dstLink} regDstE;

    typedef enum logic [1:0] {wbAlu, wbMem, wbLink} wbSrcE;

    typedef enum logic [1:0] {sizeWord, sizeHalf, sizeByte} memSizeE;

    // Branch condition, resolved in the PC unit
    typedef enum logic [2:0] {
        brNone, brEq, brNe, brGez, brLtz, brGtz, brLez
    } branchE;

    typedef enum logic [1:0] {jmpNone, jmpAbs, jmpReg} jumpE;

    typedef enum logic {extSign, extZero} immExtE;

endpackage

`default_nettype wire

// ==== decode/controller.sv ====
`default_nettype none

module controller (
    input  isaPkg::opcodeE   opcode,
    input  isaPkg::functE    funct,
    input  logic [4:0]       rtField,
    output logic             regWrite,
    output ctrlPkg::regDstE  regDst,
    output logic             aluSrc,
    output ctrlPkg::immExtE  immExt,
    output ctrlPkg::aluOpE   aluOp,
    output logic             memRead,
    output logic             memWrite,
    output ctrlPkg::memSizeE memSize,
    output ctrlPkg::wbSrcE   wbSrc,
    output ctrlPkg::branchE  branch,
    output ctrlPkg::jumpE    jump
);

    always_comb begin
        // Everything idle unless the opcode says otherwise
        regWrite = 1'b0;
        regDst   = ctrlPkg::dstRt;
        aluSrc   = 1'b0;
        immExt   = ctrlPkg::extSign;
        aluOp    = ctrlPkg::aluAdd;
        memRead  = 1'b0;
        memWrite = 1'b0;
        memSize  = ctrlPkg::sizeWord;
        wbSrc    = ctrlPkg::wbAlu;
        branch   = ctrlPkg::brNone;
        jump     = ctrlPkg::jmpNone;

        case (opcode)
            //////////////////////////////////////////////////////////////////////
            // Register and immediate arithmetic
            isaPkg::opSpecial: begin
                aluOp = ctrlPkg::aluUseFunct;
                if (funct == isaPkg::fnJr) begin
                    jump = ctrlPkg::jmpReg;
                end else if (funct inside {isaPkg::fnSll, isaPkg::fnSrl, isaPkg::fnMul,
                                           isaPkg::fnAdd, isaPkg::fnSub, isaPkg::fnAnd,
                                           isaPkg::fnOr, isaPkg::fnXor, isaPkg::fnNor,
                                           isaPkg::fnSlt}) begin
                    regWrite = 1'b1;
                    regDst   = ctrlPkg::dstRd;
                end
            end
            isaPkg::opMul: begin
                regWrite = 1'b1;
                regDst   = ctrlPkg::dstRd;
                aluOp    = ctrlPkg::aluMul;
            end
            isaPkg::opAddi, isaPkg::opSlti: begin
                regWrite = 1'b1;
                aluSrc   = 1'b1;
                aluOp    = (opcode == isaPkg::opSlti) ? ctrlPkg::aluSlt : ctrlPkg::aluAdd;
            end
            // Logical immediates zero-extend
            isaPkg::opAndi, isaPkg::opOri, isaPkg::opXori: begin
                regWrite = 1'b1;
                aluSrc   = 1'b1;
                immExt   = ctrlPkg::extZero;
                aluOp    = (opcode == isaPkg::opAndi) ? ctrlPkg::aluAnd :
                           (opcode == isaPkg::opOri)  ? ctrlPkg::aluOr  : ctrlPkg::aluXor;
            end

            //////////////////////////////////////////////////////////////////////
            // Loads and stores address memory at rs plus offset
            isaPkg::opLw, isaPkg::opLh, isaPkg::opLb: begin
                regWrite = 1'b1;
                aluSrc   = 1'b1;
                memRead  = 1'b1;
                wbSrc    = ctrlPkg::wbMem;
                memSize  = (opcode == isaPkg::opLw) ? ctrlPkg::sizeWord :
                           (opcode == isaPkg::opLh) ? ctrlPkg::sizeHalf : ctrlPkg::sizeByte;
            end
            isaPkg::opSw, isaPkg::opSh, isaPkg::opSb: begin
                aluSrc   = 1'b1;
                memWrite = 1'b1;
                memSize  = (opcode == isaPkg::opSw) ? ctrlPkg::sizeWord :
                           (opcode == isaPkg::opSh) ? ctrlPkg::sizeHalf : ctrlPkg::sizeByte;
            end

            //////////////////////////////////////////////////////////////////////
            // Branches and jumps
            isaPkg::opRegimm: begin
                case (rtField)
                    isaPkg::rmBltz: branch = ctrlPkg::brLtz;
                    isaPkg::rmBgez: branch = ctrlPkg::brGez;
                    default:        branch = ctrlPkg::brNone;
                endcase
            end
            isaPkg::opBeq:  branch = ctrlPkg::brEq;
            isaPkg::opBne:  branch = ctrlPkg::brNe;
            isaPkg::opBlez: branch = ctrlPkg::brLez;
            isaPkg::opBgtz: branch = ctrlPkg::brGtz;
            isaPkg::opJ:    jump   = ctrlPkg::jmpAbs;
            isaPkg::opJal: begin
                jump     = ctrlPkg::jmpAbs;
                regWrite = 1'b1;
                regDst   = ctrlPkg::dstLink;
                wbSrc    = ctrlPkg::wbLink;
            end
            default: ;
        endcase
    end

endmodule

`default_nettype wire

// ==== execute/alu.sv ====
`default_nettype none

`include "cpu_defs.svh"

module alu (
    input  logic             clk,
    input  ctrlPkg::aluOpE   aluOp,
    input  isaPkg::functE    funct,
    input  logic             aluSrc,
    input  ctrlPkg::immExtE  immExt,
    input  logic [`XLEN-1:0] rsData,
    input  logic [`XLEN-1:0] rtData,
    input  logic [15:0]      imm,
    input  logic [4:0]       shamt,
    output logic [`XLEN-1:0] result
);

    logic [`XLEN-1:0] immX;
    logic [`XLEN-1:0] opB;
    ctrlPkg::aluOpE   op;

    assign immX = (immExt == ctrlPkg::extSign) ? {{(`XLEN-16){imm[15]}}, imm}
                                               : {{(`XLEN-16){1'b0}}, imm};
    assign opB  = aluSrc ? immX : rtData;

    // R-type ops come from the function field
    always_comb begin
        op = aluOp;
        if (aluOp == ctrlPkg::aluUseFunct) begin
            case (funct)
                isaPkg::fnSll: op = ctrlPkg::aluSll;
                isaPkg::fnSrl: op = ctrlPkg::aluSrl;
                isaPkg::fnMul: op = ctrlPkg::aluMul;
                isaPkg::fnSub: op = ctrlPkg::aluSub;
                isaPkg::fnAnd: op = ctrlPkg::aluAnd;
                isaPkg::fnOr:  op = ctrlPkg::aluOr;
                isaPkg::fnXor: op = ctrlPkg::aluXor;
                isaPkg::fnNor: op = ctrlPkg::aluNor;
                isaPkg::fnSlt: op = ctrlPkg::aluSlt;
                default:       op = ctrlPkg::aluAdd;
            endcase
        end
    end

    always_comb begin
        case (op)
            ctrlPkg::aluAdd: result = rsData + opB;
            ctrlPkg::aluSub: result = rsData - opB;
            ctrlPkg::aluAnd: result = rsData & opB;
            ctrlPkg::aluOr:  result = rsData | opB;
            ctrlPkg::aluXor: result = rsData ^ opB;
            ctrlPkg::aluNor: result = ~(rsData | opB);
            ctrlPkg::aluSlt: result = {{(`XLEN-1){1'b0}}, $signed(rsData) < $signed(opB)};
            // Shifts act on rt by shamt
            ctrlPkg::aluSll: result = rtData << shamt;
            ctrlPkg::aluSrl: result = rtData >> shamt;
            // Low word of the product
            ctrlPkg::aluMul: result = rsData * opB;
            default:         result = '0;
        endcase
    end

    // Function decode only for register-register forms
    aluFunctNoImm: assert property (@(posedge clk) (aluOp == ctrlPkg::aluUseFunct) |-> !aluSrc)
        else $error("alu: function decode with immediate operand");

endmodule

`default_nettype wire

// ==== logic/regFile.sv ====
`default_nettype none

`include "cpu_defs.svh"

module regFile (
    input  logic             clk,
    input  logic             arstN,
    input  logic             regWrite,
    input  ctrlPkg::regDstE  regDst,
    input  ctrlPkg::wbSrcE   wbSrc,
    input  logic [4:0]       rsAddr,
    input  logic [4:0]       rtAddr,
    input  logic [4:0]       rdAddr,
    input  logic [`XLEN-1:0] aluResult,
    input  logic [`XLEN-1:0] loadData,
    input  logic [`XLEN-1:0] linkAddr,
    output logic [`XLEN-1:0] rsData,
    output logic [`XLEN-1:0] rtData,
    output logic             wbEn,
    output logic [4:0]       wbReg,
    output logic [`XLEN-1:0] wbData
);

    logic [`XLEN-1:0] regs [`REG_COUNT];

    always_comb begin
        case (regDst)
            ctrlPkg::dstRd:   wbReg = rdAddr;
            ctrlPkg::dstLink: wbReg = 5'(`REG_COUNT - 1);
            default:          wbReg = rtAddr;
        endcase
        case (wbSrc)
            ctrlPkg::wbMem:  wbData = loadData;
            ctrlPkg::wbLink: wbData = linkAddr;
            default:         wbData = aluResult;
        endcase
    end

    // No retire during reset or to r0
    assign wbEn   = regWrite && arstN && (wbReg != '0);
    assign rsData = (rsAddr == '0) ? '0 : regs[rsAddr];
    assign rtData = (rtAddr == '0) ? '0 : regs[rtAddr];

    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            regs <= '{default: '0};
        end else if (wbEn) begin
            regs[wbReg] <= wbData;
        end
    end

    wbRegInRange: assert property (@(posedge clk) disable iff (!arstN)
        wbEn |-> (wbReg < `REG_COUNT))
        else $error("regFile: bad writeback register %0d", wbReg);

endmodule

`default_nettype wire

// ==== logic/dataMem.sv ====
`default_nettype none

`include "cpu_defs.svh"

module dataMem (
    input  logic              clk,
    input  logic              arstN,
    input  logic              memRead,
    input  logic              memWrite,
    input  ctrlPkg::memSizeE  memSize,
    input  logic [`XLEN-1:0]  addr,
    input  logic [`XLEN-1:0]  storeData,
    output logic [`XLEN-1:0]  loadData
);

    localparam int AddrW = $clog2(`DMEM_BYTES);

    logic [7:0]       mem [`DMEM_BYTES];
    logic [AddrW-1:0] a0;
    logic [AddrW-1:0] a1;
    logic [AddrW-1:0] a2;
    logic [AddrW-1:0] a3;

    // Little-endian lanes wrap inside the array
    assign a0 = addr[AddrW-1:0];
    assign a1 = a0 + AddrW'(1);
    assign a2 = a0 + AddrW'(2);
    assign a3 = a0 + AddrW'(3);

    always_comb begin
        loadData = '0;
        if (memRead) begin
            case (memSize)
                ctrlPkg::sizeHalf: loadData = {{(`XLEN-16){mem[a1][7]}}, mem[a1], mem[a0]};
                ctrlPkg::sizeByte: loadData = {{(`XLEN-8){mem[a0][7]}}, mem[a0]};
                default:           loadData = {mem[a3], mem[a2], mem[a1], mem[a0]};
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (memWrite && arstN) begin
            mem[a0] <= storeData[7:0];
            if (memSize != ctrlPkg::sizeByte) begin
                mem[a1] <= storeData[15:8];
            end
            if (memSize == ctrlPkg::sizeWord) begin
                mem[a2] <= storeData[23:16];
                mem[a3] <= storeData[31:24];
            end
        end
    end

    memAligned: assert property (@(posedge clk) disable iff (!arstN)
        (memRead || memWrite) |->
            (memSize == ctrlPkg::sizeByte) ||
            (memSize == ctrlPkg::sizeHalf && !addr[0]) ||
            (memSize == ctrlPkg::sizeWord && addr[1:0] == 2'b00))
        else $error("dataMem: misaligned access at %h", addr);

endmodule

`default_nettype wire

// ==== logic/pcUnit.sv ====
`default_nettype none

`include "cpu_defs.svh"

module pcUnit (
    input  logic             clk,
    input  logic             arstN,
    input  ctrlPkg::branchE  branch,
    input  ctrlPkg::jumpE    jump,
    input  logic [`XLEN-1:0] rsData,
    input  logic [`XLEN-1:0] rtData,
    input  logic [15:0]      imm,
    input  logic [25:0]      target,
    output logic [`XLEN-1:0] pc,
    output logic [`XLEN-1:0] linkAddr
);

    logic             taken;
    logic             rsZero;
    logic [`XLEN-1:0] branchAddr;
    logic [`XLEN-1:0] pcNext;

    assign linkAddr   = pc + 4;
    assign branchAddr = linkAddr + {{(`XLEN-18){imm[15]}}, imm, 2'b00};
    assign rsZero     = (rsData == '0);

    // Conditions on rs alone, except eq and ne
    always_comb begin
        case (branch)
            ctrlPkg::brEq:  taken = (rsData == rtData);
            ctrlPkg::brNe:  taken = (rsData != rtData);
            ctrlPkg::brGez: taken = !rsData[`XLEN-1];
            ctrlPkg::brLtz: taken = rsData[`XLEN-1];
            ctrlPkg::brGtz: taken = !rsData[`XLEN-1] && !rsZero;
            ctrlPkg::brLez: taken = rsData[`XLEN-1] || rsZero;
            default:        taken = 1'b0;
        endcase
    end

    always_comb begin
        if (jump == ctrlPkg::jmpReg) begin
            pcNext = rsData;
        end else if (jump == ctrlPkg::jmpAbs) begin
            pcNext = {linkAddr[`XLEN-1:28], target, 2'b00};
        end else if (taken) begin
            pcNext = branchAddr;
        end else begin
            pcNext = linkAddr;
        end
    end

    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            pc <= '0;
        end else begin
            pc <= pcNext;
        end
    end

endmodule

`default_nettype wire

// ==== logic/cpuTop.sv ====
`default_nettype none

`include "cpu_defs.svh"

module cpuTop (
    input  logic             clk,
    input  logic             arstN,
    input  logic [31:0]      instr,
    output logic [`XLEN-1:0] pc,
    output logic             wbEn,
    output logic [4:0]       wbReg,
    output logic [`XLEN-1:0] wbData,
    output logic             memWe
);

    //////////////////////////////////////////////////////////////////////
    // Instruction fields
    isaPkg::opcodeE   opcode;
    isaPkg::functE    funct;
    logic [4:0]       rsAddr;
    logic [4:0]       rtAddr;
    logic [4:0]       rdAddr;
    logic [4:0]       shamt;
    logic [15:0]      imm;
    logic [25:0]      target;

    // Controls
    logic             regWrite;
    ctrlPkg::regDstE  regDst;
    logic             aluSrc;
    ctrlPkg::immExtE  immExt;
    ctrlPkg::aluOpE   aluOp;
    logic             memRead;
    logic             memWrite;
    ctrlPkg::memSizeE memSize;
    ctrlPkg::wbSrcE   wbSrc;
    ctrlPkg::branchE  branch;
    ctrlPkg::jumpE    jump;

    // Datapath
    logic [`XLEN-1:0] rsData;
    logic [`XLEN-1:0] rtData;
    logic [`XLEN-1:0] aluResult;
    logic [`XLEN-1:0] loadData;
    logic [`XLEN-1:0] linkAddr;

    assign opcode = isaPkg::opcodeE'(instr[31:26]);
    assign rsAddr = instr[25:21];
    assign rtAddr = instr[20:16];
    assign rdAddr = instr[15:11];
    assign shamt  = instr[10:6];
    assign funct  = isaPkg::functE'(instr[5:0]);
    assign imm    = instr[15:0];
    assign target = instr[25:0];

    // Store strobe as seen outside, quiet in reset
    assign memWe  = memWrite && arstN;

    //////////////////////////////////////////////////////////////////////
    // Blocks
    controller ctrl_i (
        .opcode, .funct, .rtField(rtAddr),
        .regWrite, .regDst, .aluSrc, .immExt, .aluOp,
        .memRead, .memWrite, .memSize, .wbSrc, .branch, .jump
    );

    alu alu_i (
        .clk, .aluOp, .funct, .aluSrc, .immExt,
        .rsData, .rtData, .imm, .shamt,
        .result(aluResult)
    );

    regFile regs_i (
        .clk, .arstN, .regWrite, .regDst, .wbSrc,
        .rsAddr, .rtAddr, .rdAddr,
        .aluResult, .loadData, .linkAddr,
        .rsData, .rtData, .wbEn, .wbReg, .wbData
    );

    dataMem dmem_i (
        .clk, .arstN, .memRead, .memWrite, .memSize,
        .addr(aluResult), .storeData(rtData), .loadData
    );

    pcUnit pc_i (
        .clk, .arstN, .branch, .jump,
        .rsData, .rtData, .imm, .target,
        .pc, .linkAddr
    );

endmodule

`default_nettype wire

// ==== testbench/cpuVectors.svh ====
`ifndef CPU_VECTORS_SVH
`define CPU_VECTORS_SVH

// Columns: instruction word, pc while it executes, wbEn, wbReg, wbData, memWe
// wbReg and wbData only count when wbEn is expected high
typedef struct packed {
    logic [31:0] instr;
    logic [31:0] pc;
    logic        wbEn;
    logic [4:0]  wbReg;
    logic [31:0] wbData;
    logic        memWe;
} vecT;

localparam int NumVec = 45;

localparam vecT Vectors [NumVec] = '{
    // Immediates
    '{32'h2001FFFB, 32'h00000000, 1'b1, 5'd1,  32'hFFFFFFFB, 1'b0},  // addi r1,r0,-5
    '{32'h34028001, 32'h00000004, 1'b1, 5'd2,  32'h00008001, 1'b0},  // ori r2,r0,0x8001
    '{32'h28230001, 32'h00000008, 1'b1, 5'd3,  32'h00000001, 1'b0},  // slti r3,r1,1
    '{32'h2004000C, 32'h0000000C, 1'b1, 5'd4,  32'h0000000C, 1'b0},  // addi r4,r0,12
    // Register forms
    '{32'h00242820, 32'h00000010, 1'b1, 5'd5,  32'h00000007, 1'b0},  // add r5,r1,r4
    '{32'h00243022, 32'h00000014, 1'b1, 5'd6,  32'hFFFFFFEF, 1'b0},  // sub r6,r1,r4
    '{32'h00243824, 32'h00000018, 1'b1, 5'd7,  32'h00000008, 1'b0},  // and r7,r1,r4
    '{32'h00444025, 32'h0000001C, 1'b1, 5'd8,  32'h0000800D, 1'b0},  // or r8,r2,r4
    '{32'h00244826, 32'h00000020, 1'b1, 5'd9,  32'hFFFFFFF7, 1'b0},  // xor r9,r1,r4
    '{32'h00445027, 32'h00000024, 1'b1, 5'd10, 32'hFFFF7FF2, 1'b0},  // nor r10,r2,r4
    '{32'h0024582A, 32'h00000028, 1'b1, 5'd11, 32'h00000001, 1'b0},  // slt r11,r1,r4
    '{32'h00046100, 32'h0000002C, 1'b1, 5'd12, 32'h000000C0, 1'b0},  // sll r12,r4,4
    '{32'h00016F02, 32'h00000030, 1'b1, 5'd13, 32'h0000000F, 1'b0},  // srl r13,r1,28
    '{32'h00247018, 32'h00000034, 1'b1, 5'd14, 32'hFFFFFFC4, 1'b0},  // mul r14,r1,r4 (funct)
    '{32'h70847802, 32'h00000038, 1'b1, 5'd15, 32'h00000090, 1'b0},  // mul r15,r4,r4 (opcode)
    // Memory
    '{32'hAC810000, 32'h0000003C, 1'b0, 5'd0,  32'h00000000, 1'b1},  // sw r1,0(r4)
    '{32'h8C900000, 32'h00000040, 1'b1, 5'd16, 32'hFFFFFFFB, 1'b0},  // lw r16,0(r4)
    '{32'h20110080, 32'h00000044, 1'b1, 5'd17, 32'h00000080, 1'b0},  // addi r17,r0,0x80
    '{32'hA0910011, 32'h00000048, 1'b0, 5'd0,  32'h00000000, 1'b1},  // sb r17,17(r4)
    '{32'h80920011, 32'h0000004C, 1'b1, 5'd18, 32'hFFFFFF80, 1'b0},  // lb r18,17(r4)
    '{32'hA4820004, 32'h00000050, 1'b0, 5'd0,  32'h00000000, 1'b1},  // sh r2,4(r4)
    '{32'h84930004, 32'h00000054, 1'b1, 5'd19, 32'hFFFF8001, 1'b0},  // lh r19,4(r4)
    // Branches
    '{32'h10300002, 32'h00000058, 1'b0, 5'd0,  32'h00000000, 1'b0},  // beq r1,r16 taken
    '{32'h10240005, 32'h00000064, 1'b0, 5'd0,  32'h00000000, 1'b0},  // beq r1,r4 not taken
    '{32'h14240001, 32'h00000068, 1'b0, 5'd0,  32'h00000000, 1'b0},  // bne r1,r4 taken
    '{32'h04210003, 32'h00000070, 1'b0, 5'd0,  32'h00000000, 1'b0},  // bgez neg
    '{32'h04010001, 32'h00000074, 1'b0, 5'd0,  32'h00000000, 1'b0},  // bgez zero
    '{32'h04200001, 32'h0000007C, 1'b0, 5'd0,  32'h00000000, 1'b0},  // bltz neg
    '{32'h04A00001, 32'h00000084, 1'b0, 5'd0,  32'h00000000, 1'b0},  // bltz pos
    '{32'h1CA00001, 32'h00000088, 1'b0, 5'd0,  32'h00000000, 1'b0},  // bgtz pos
    '{32'h1C000001, 32'h00000090, 1'b0, 5'd0,  32'h00000000, 1'b0},  // bgtz zero
    '{32'h18200001, 32'h00000094, 1'b0, 5'd0,  32'h00000000, 1'b0},  // blez neg
    '{32'h18000001, 32'h0000009C, 1'b0, 5'd0,  32'h00000000, 1'b0},  // blez zero
    '{32'h18A00001, 32'h000000A4, 1'b0, 5'd0,  32'h00000000, 1'b0},  // blez pos
    '{32'h04A10001, 32'h000000A8, 1'b0, 5'd0,  32'h00000000, 1'b0},  // bgez pos
    '{32'h04000001, 32'h000000B0, 1'b0, 5'd0,  32'h00000000, 1'b0},  // bltz zero
    '{32'h1C200001, 32'h000000B4, 1'b0, 5'd0,  32'h00000000, 1'b0},  // bgtz neg
    '{32'h1000FFF8, 32'h000000B8, 1'b0, 5'd0,  32'h00000000, 1'b0},  // beq backward
    // Jumps
    '{32'h08000040, 32'h0000009C, 1'b0, 5'd0,  32'h00000000, 1'b0},  // j 0x100
    '{32'h0C000080, 32'h00000100, 1'b1, 5'd31, 32'h00000104, 1'b0},  // jal 0x200
    '{32'h03E00008, 32'h00000200, 1'b0, 5'd0,  32'h00000000, 1'b0},  // jr r31
    // r0 and unknown opcode
    '{32'h20000005, 32'h00000104, 1'b0, 5'd0,  32'h00000000, 1'b0},  // addi r0,r0,5
    '{32'h0004A020, 32'h00000108, 1'b1, 5'd20, 32'h0000000C, 1'b0},  // add r20,r0,r4
    '{32'hFC000000, 32'h0000010C, 1'b0, 5'd0,  32'h00000000, 1'b0},  // opcode 0x3F
    '{32'h20150001, 32'h00000110, 1'b1, 5'd21, 32'h00000001, 1'b0}   // addi r21,r0,1
};

`endif

// ==== testbench/cpuTb.sv ====
`default_nettype none

module cpuTb;

    `include "cpuVectors.svh"

    // Table plus reset plus slack
    localparam int CycleLimit = NumVec + 5 + 20;

    logic        clk;
    logic        arstN;
    logic [31:0] instr;
    logic [31:0] pc;
    logic        wbEn;
    logic [4:0]  wbReg;
    logic [31:0] wbData;
    logic        memWe;

    int cycles = 0;
    int passCount = 0;
    int failCount = 0;
    int checkFails = 0;

    cpuTop dut_i (
        .clk, .arstN, .instr,
        .pc, .wbEn, .wbReg, .wbData, .memWe
    );

    initial clk = 1'b0;
    always #2 clk = ~clk;

    //////////////////////////////////////////////////////////////////////
    // Watchdog
    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycles >= CycleLimit) begin
            $display("Run hung: still going after %0d cycles", cycles);
            $display("TESTS FAILED");
            $finish;
        end
    end

    // Close out one test from the number of failed checks it caused
    task automatic reportTest(input string name, input int startFails);
        if (checkFails == startFails) begin
            passCount++;
            $display("Test %s: ok", name);
        end else begin
            failCount++;
            $display("Test %s: %0d check(s) wrong", name, checkFails - startFails);
        end
    endtask

    // During reset nothing may retire
    task automatic checkQuiet(input string name);
        int startFails;
        startFails = checkFails;
        assert (pc === 32'h0) else begin
            $display("Fail at time %0t: %s pc %h, expected 0", $time, name, pc);
            checkFails++;
        end
        assert (wbEn === 1'b0) else begin
            $display("Fail at time %0t: %s wbEn high in reset", $time, name);
            checkFails++;
        end
        assert (memWe === 1'b0) else begin
            $display("Fail at time %0t: %s memWe high in reset", $time, name);
            checkFails++;
        end
        reportTest(name, startFails);
    endtask

    task automatic checkEntry(input int idx, input vecT v);
        int startFails;
        startFails = checkFails;
        assert (pc === v.pc) else begin
            $display("Fail at time %0t: entry %0d pc %h, expected %h", $time, idx, pc, v.pc);
            checkFails++;
        end
        assert (wbEn === v.wbEn) else begin
            $display("Fail at time %0t: entry %0d wbEn %b, expected %b",
                     $time, idx, wbEn, v.wbEn);
            checkFails++;
        end
        // Destination and value only matter on a real write
        if (v.wbEn) begin
            assert (wbReg === v.wbReg) else begin
                $display("Fail at time %0t: entry %0d wbReg %0d, expected %0d",
                         $time, idx, wbReg, v.wbReg);
                checkFails++;
            end
            assert (wbData === v.wbData) else begin
                $display("Fail at time %0t: entry %0d wbData %h, expected %h",
                         $time, idx, wbData, v.wbData);
                checkFails++;
            end
        end
        assert (memWe === v.memWe) else begin
            $display("Fail at time %0t: entry %0d memWe %b, expected %b",
                     $time, idx, memWe, v.memWe);
            checkFails++;
        end
        reportTest($sformatf("%0d (instr %h)", idx, v.instr), startFails);
    endtask

    //////////////////////////////////////////////////////////////////////
    // Stimulus
    initial begin
        arstN = 1'b0;
        instr = 32'h0;

        // Try a write and a store while reset is held
        repeat (2) @(negedge clk);
        instr = 32'h2001FFFB;
        #1;
        checkQuiet("reset addi");
        @(negedge clk);
        instr = 32'hAC810000;
        #1;
        checkQuiet("reset sw");
        @(negedge clk);
        instr = 32'h0;
        @(negedge clk);
        arstN = 1'b1;

        for (int i = 0; i < NumVec; i++) begin
            instr = Vectors[i].instr;
            #1;
            checkEntry(i, Vectors[i]);
            @(negedge clk);
        end

        $display("Summary: %0d passed, %0d failed", passCount, failCount);
        if (failCount == 0 && checkFails == 0) begin
            $display("TESTS PASSED");
        end else begin
            $display("TESTS FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== project.f ====
+incdir+common
+incdir+testbench
common/isaPkg.sv
common/ctrlPkg.sv
decode/controller.sv
execute/alu.sv
logic/regFile.sv
logic/dataMem.sv
logic/pcUnit.sv
logic/cpuTop.sv
testbench/cpuTb.sv

// ==== run.sh ====
#!/bin/sh
# Build and run the cpuTb simulation with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --assert -f project.f --top-module cpuTb -o cpuSim > build.log 2>&1
if [ $? -ne 0 ]; then
    cat build.log
    echo "Verilator build failed"
    exit 1
fi

./obj_dir/cpuSim > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi

if grep -q "TESTS FAILED" sim.log; then
    exit 1
fi
exit 0
